//--- project.f
+incdir+test
source/core_cfg_pkg.sv
source/uop_pkg.sv
source/iq_dispatch.sv
source/iq_entry.sv
source/issue_select.sv
source/wakeup_merge.sv
source/issue_top.sv
test/issue_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the issue stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f project.f \
    --top-module issue_tb \
    -o issue_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/issue_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
    exit 0
fi
exit 1

//--- test/issue_ref.svh
`ifndef ISSUE_REF_SVH
`define ISSUE_REF_SVH

// Fibonacci LFSR, taps 32, 22, 2, 1.
logic [31:0] lfsr_state = 32'h0ff6_100c;

// Wakeup cycles seen on the bus, per register, with en and we both high.
int wake_q [PREG_NUM][$];

// Takes n bits, one LFSR step per bit.
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        v          = {v[30:0], fb};
    end
    return v;
endfunction

// Cycle from which a source counts as ready, or -1 if never woken.
// A source whose last writer went in at cycle lw needs a wakeup at lw+1 or later.
function automatic int src_time(input int r, input int from, input int disp);
    int w;
    if (from < 0) begin
        return disp;
    end
    w = -1;
    foreach (wake_q[r][i]) begin
        if (wake_q[r][i] >= from && (w < 0 || wake_q[r][i] < w)) begin
            w = wake_q[r][i];
        end
    end
    if (w < 0) begin
        return -1;
    end
    return (w > disp) ? w : disp;
endfunction

// Slot turns READY one cycle after the later source, is picked, then registered.
function automatic int earliest_issue(input int t1, input int t2);
    if (t1 < 0 || t2 < 0) begin
        return -1;
    end
    return ((t1 > t2) ? t1 : t2) + 2;
endfunction

`endif

//--- test/issue_tb.sv
`default_nettype none

module issue_tb;

    import core_cfg_pkg::*;
    import uop_pkg::*;

    `include "issue_ref.svh"

    localparam int CLK_PERIOD = 40;
    localparam int N_UOPS     = 100;
    localparam int MAX_UOPS   = 128;

    logic clk;
    logic rst_n;
    logic disp_valid;
    uop_op_e disp_op;
    logic [PREG_WIDTH-1:0] disp_rs1;
    logic [PREG_WIDTH-1:0] disp_rs2;
    logic [PREG_WIDTH-1:0] disp_rd;
    logic disp_we;
    logic disp_ready;
    logic muldiv_wakeup_en;
    logic muldiv_wakeup_we;
    logic [PREG_WIDTH-1:0] muldiv_wakeup_rd;
    logic [LOAD_PIPELINE-1:0] load_wakeup_en;
    logic [LOAD_PIPELINE-1:0] load_wakeup_we;
    logic [LOAD_PIPELINE-1:0][PREG_WIDTH-1:0] load_wakeup_rd;
    logic [ALU_SIZE-1:0] issue_valid;
    uop_op_e [ALU_SIZE-1:0] issue_op;
    logic [ALU_SIZE-1:0][PREG_WIDTH-1:0] issue_rd;
    logic [ALU_SIZE-1:0][PREG_WIDTH-1:0] issue_rs1;
    logic [ALU_SIZE-1:0][PREG_WIDTH-1:0] issue_rs2;
    logic [WAKEUP_SIZE-1:0] wakeup_en;
    logic [WAKEUP_SIZE-1:0] wakeup_we;
    logic [WAKEUP_SIZE-1:0][PREG_WIDTH-1:0] wakeup_rd;

    // Scoreboard of dispatched micro-ops.
    logic [2:0] u_op [MAX_UOPS];
    int u_rs1 [MAX_UOPS];
    int u_rs2 [MAX_UOPS];
    int u_rd [MAX_UOPS];
    logic u_we [MAX_UOPS];
    int u_disp [MAX_UOPS];
    int u_from1 [MAX_UOPS];
    int u_from2 [MAX_UOPS];
    logic u_live [MAX_UOPS];
    int last_writer [PREG_NUM];
    int issue_cyc [PREG_NUM];
    int n_disp = 0;
    int n_issued = 0;
    int errors = 0;
    int cycle = 0;
    logic side_random = 1'b0;

    issue_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string name, input int exp, input int got);
        errors++;
        $display("MISMATCH t=%0t %s expected=%0h got=%0h", $time, name, exp, got);
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    function automatic int find_uop(input int l);
        for (int k = 0; k < n_disp; k++) begin
            if (u_live[k] && u_op[k] == issue_op[l] && u_rd[k] == int'(issue_rd[l]) &&
                u_rs1[k] == int'(issue_rs1[l]) && u_rs2[k] == int'(issue_rs2[l])) begin
                return k;
            end
        end
        return -1;
    endfunction

    function automatic int live_count();
        int n;
        n = 0;
        for (int k = 0; k < n_disp; k++) begin
            n += int'(u_live[k]);
        end
        return n;
    endfunction

    // ----------------------------------------
    // Compare process
    // ----------------------------------------

    logic prev_muldiv = 1'b0;
    logic [ALU_SIZE-1:0] prev_lane_en = '0;
    logic [ALU_SIZE-1:0] prev_lane_we = '0;
    logic [ALU_SIZE-1:0][PREG_WIDTH-1:0] prev_lane_rd = '0;
    int midx [ALU_SIZE];
    int t_exp;

    always @(posedge clk) begin
        if (rst_n) begin
            assert (!(prev_muldiv && issue_valid[0]))
            else report_error("lane 0 issued right after a multiply/divide wakeup");
            if (muldiv_wakeup_en) begin
                assert (wakeup_en[0] && wakeup_rd[0] == muldiv_wakeup_rd &&
                        wakeup_we[0] == muldiv_wakeup_we)
                else report_mismatch("wakeup_rd[0]", int'(muldiv_wakeup_rd), int'(wakeup_rd[0]));
                if (muldiv_wakeup_we) begin
                    wake_q[muldiv_wakeup_rd].push_back(cycle);
                end
            end
            assert (wakeup_en[ALU_SIZE] == load_wakeup_en[0] &&
                    wakeup_we[ALU_SIZE] == load_wakeup_we[0])
            else report_mismatch("wakeup_en[load]", int'(load_wakeup_en[0]),
                                 int'(wakeup_en[ALU_SIZE]));
            if (load_wakeup_en[0]) begin
                assert (wakeup_rd[ALU_SIZE] == load_wakeup_rd[0])
                else report_mismatch("wakeup_rd[load]", int'(load_wakeup_rd[0]),
                                     int'(wakeup_rd[ALU_SIZE]));
                if (load_wakeup_we[0]) begin
                    wake_q[load_wakeup_rd[0]].push_back(cycle);
                end
            end
            // Picks were one cycle earlier, and so were their wakeups.
            for (int l = 0; l < ALU_SIZE; l++) begin
                midx[l] = -1;
                if (issue_valid[l]) begin
                    midx[l] = find_uop(l);
                    assert (midx[l] >= 0)
                    else report_error("issue matches no outstanding dispatched micro-op");
                    if (midx[l] >= 0) begin
                        u_live[midx[l]] = 1'b0;
                        n_issued++;
                        issue_cyc[u_rd[midx[l]]] = cycle;
                        if (u_we[midx[l]]) begin
                            wake_q[u_rd[midx[l]]].push_back(cycle - 1);
                        end
                    end
                end
            end
            for (int l = 0; l < ALU_SIZE; l++) begin
                if (midx[l] >= 0) begin
                    t_exp = earliest_issue(
                        src_time(u_rs1[midx[l]], u_from1[midx[l]], u_disp[midx[l]]),
                        src_time(u_rs2[midx[l]], u_from2[midx[l]], u_disp[midx[l]]));
                    assert (t_exp >= 0 && cycle >= t_exp)
                    else report_error($sformatf("micro-op issued at cycle %0d, earliest %0d",
                                                cycle, t_exp));
                end
            end
            // Each issue was broadcast on its own lane in its pick cycle.
            for (int l = 0; l < ALU_SIZE; l++) begin
                if (!(l == MULDIV_LANE && prev_muldiv)) begin
                    assert (prev_lane_en[l] == (midx[l] >= 0))
                    else report_mismatch($sformatf("wakeup_en[%0d]", l), int'(midx[l] >= 0),
                                         int'(prev_lane_en[l]));
                    if (midx[l] >= 0 && prev_lane_en[l]) begin
                        assert (prev_lane_we[l] == u_we[midx[l]])
                        else report_mismatch($sformatf("wakeup_we[%0d]", l),
                                             int'(u_we[midx[l]]), int'(prev_lane_we[l]));
                        assert (int'(prev_lane_rd[l]) == u_rd[midx[l]])
                        else report_mismatch($sformatf("wakeup_rd[%0d]", l), u_rd[midx[l]],
                                             int'(prev_lane_rd[l]));
                    end
                end
            end
            assert (disp_ready == (live_count() < IQ_DEPTH))
            else report_mismatch("disp_ready", int'(live_count() < IQ_DEPTH), int'(disp_ready));
            if (disp_valid && disp_ready) begin
                u_op[n_disp]    = disp_op;
                u_rs1[n_disp]   = int'(disp_rs1);
                u_rs2[n_disp]   = int'(disp_rs2);
                u_rd[n_disp]    = int'(disp_rd);
                u_we[n_disp]    = disp_we;
                u_disp[n_disp]  = cycle;
                u_from1[n_disp] = (disp_rs1 == '0 || last_writer[disp_rs1] < 0) ?
                                  -1 : last_writer[disp_rs1] + 1;
                u_from2[n_disp] = (disp_rs2 == '0 || last_writer[disp_rs2] < 0) ?
                                  -1 : last_writer[disp_rs2] + 1;
                u_live[n_disp]  = 1'b1;
                if (disp_we && disp_rd != '0) begin
                    last_writer[disp_rd] = cycle;
                end
                n_disp++;
            end
            prev_muldiv  = muldiv_wakeup_en;
            prev_lane_en = wakeup_en[ALU_SIZE-1:0];
            prev_lane_we = wakeup_we[ALU_SIZE-1:0];
            prev_lane_rd = wakeup_rd[ALU_SIZE-1:0];
        end
        cycle++;
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    task automatic drive_side();
        muldiv_wakeup_en  = side_random && (rand_bits(2) == 0);
        muldiv_wakeup_we  = rand_bits(1) != 0;
        muldiv_wakeup_rd  = PREG_WIDTH'(rand_bits(4));
        load_wakeup_en[0] = side_random && (rand_bits(2) == 0);
        load_wakeup_we[0] = rand_bits(1) != 0;
        load_wakeup_rd[0] = PREG_WIDTH'(rand_bits(4));
    endtask

    task automatic dispatch_uop(input int op, input int rs1, input int rs2, input int rd,
                                input logic we);
        while (!disp_ready) begin
            drive_side();
            @(negedge clk);
        end
        drive_side();
        disp_valid = 1'b1;
        disp_op    = uop_op_e'(3'(op));
        disp_rs1   = PREG_WIDTH'(rs1);
        disp_rs2   = PREG_WIDTH'(rs2);
        disp_rd    = PREG_WIDTH'(rd);
        disp_we    = we;
        @(negedge clk);
        disp_valid = 1'b0;
    endtask

    task automatic drain();
        side_random = 1'b0;
        while (live_count() > 0 || disp_valid) begin
            drive_side();
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    initial begin
        int gap;
        rst_n = 1'b0;
        disp_valid = 1'b0;
        disp_op = OP_ADD;
        disp_rs1 = '0;
        disp_rs2 = '0;
        disp_rd = '0;
        disp_we = 1'b0;
        muldiv_wakeup_en = 1'b0;
        muldiv_wakeup_we = 1'b0;
        muldiv_wakeup_rd = '0;
        load_wakeup_en = '0;
        load_wakeup_we = '0;
        load_wakeup_rd = '0;
        foreach (last_writer[r]) last_writer[r] = -1;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Back-to-back dependent pair.
        dispatch_uop(0, 0, 0, 12, 1'b1);
        dispatch_uop(1, 12, 0, 13, 1'b1);
        drain();
        assert (issue_cyc[13] - issue_cyc[12] == 1)
        else report_mismatch("dependent issue distance", 1, issue_cyc[13] - issue_cyc[12]);

        side_random = 1'b1;
        for (int k = 0; k < N_UOPS; k++) begin
            gap = int'(rand_bits(2));
            repeat (gap) begin
                drive_side();
                @(negedge clk);
            end
            dispatch_uop(int'(rand_bits(3)) % 6, int'(rand_bits(4)), int'(rand_bits(4)),
                         int'(rand_bits(4)), rand_bits(2) != 0);
        end
        drain();

        assert (n_issued == n_disp)
        else report_mismatch("issued count", n_disp, n_issued);
        $display("dispatched %0d, issued %0d, errors %0d", n_disp, n_issued, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        #(CLK_PERIOD * (40 * N_UOPS + 8));
        $display("Timeout: micro-ops still outstanding after %0d cycles", cycle);
        $display("dispatched %0d, issued %0d, errors %0d", n_disp, n_issued, errors + 1);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/issue_top.sv
`default_nettype none

module issue_top (
    input  logic                                                        clk,
    input  logic                                                        rst_n,
    input  logic                                                        disp_valid,
    input  uop_pkg::uop_op_e                                            disp_op,
    input  logic [core_cfg_pkg::PREG_WIDTH-1:0]                         disp_rs1,
    input  logic [core_cfg_pkg::PREG_WIDTH-1:0]                         disp_rs2,
    input  logic [core_cfg_pkg::PREG_WIDTH-1:0]                         disp_rd,
    input  logic                                                        disp_we,
    output logic                                                        disp_ready,
    input  logic                                                        muldiv_wakeup_en,
    input  logic                                                        muldiv_wakeup_we,
    input  logic [core_cfg_pkg::PREG_WIDTH-1:0]                         muldiv_wakeup_rd,
    input  logic [core_cfg_pkg::LOAD_PIPELINE-1:0]                      load_wakeup_en,
    input  logic [core_cfg_pkg::LOAD_PIPELINE-1:0]                      load_wakeup_we,
    input  logic [core_cfg_pkg::LOAD_PIPELINE-1:0][core_cfg_pkg::PREG_WIDTH-1:0] load_wakeup_rd,
    output logic [core_cfg_pkg::ALU_SIZE-1:0]                           issue_valid,
    output uop_pkg::uop_op_e [core_cfg_pkg::ALU_SIZE-1:0]               issue_op,
    output logic [core_cfg_pkg::ALU_SIZE-1:0][core_cfg_pkg::PREG_WIDTH-1:0] issue_rd,
    output logic [core_cfg_pkg::ALU_SIZE-1:0][core_cfg_pkg::PREG_WIDTH-1:0] issue_rs1,
    output logic [core_cfg_pkg::ALU_SIZE-1:0][core_cfg_pkg::PREG_WIDTH-1:0] issue_rs2,
    output logic [core_cfg_pkg::WAKEUP_SIZE-1:0]                        wakeup_en,
    output logic [core_cfg_pkg::WAKEUP_SIZE-1:0]                        wakeup_we,
    output logic [core_cfg_pkg::WAKEUP_SIZE-1:0][core_cfg_pkg::PREG_WIDTH-1:0] wakeup_rd
);

    import core_cfg_pkg::*;
    import uop_pkg::*;

    logic [IQ_DEPTH-1:0]   entry_free;
    logic [IQ_DEPTH-1:0]   alloc;
    uop_op_e               alloc_op;
    logic [PREG_WIDTH-1:0] alloc_rs1;
    logic [PREG_WIDTH-1:0] alloc_rs2;
    logic [PREG_WIDTH-1:0] alloc_rd;
    logic                  alloc_we;
    logic                  alloc_rs1_rdy;
    logic                  alloc_rs2_rdy;

    entry_state_e [IQ_DEPTH-1:0]         entry_state;
    uop_op_e [IQ_DEPTH-1:0]              entry_op;
    logic [IQ_DEPTH-1:0][PREG_WIDTH-1:0] entry_rs1;
    logic [IQ_DEPTH-1:0][PREG_WIDTH-1:0] entry_rs2;
    logic [IQ_DEPTH-1:0][PREG_WIDTH-1:0] entry_rd;
    logic [IQ_DEPTH-1:0]                 entry_we;
    logic [IQ_DEPTH-1:0]                 clear;

    logic [ALU_SIZE-1:0]                 lane_ready;
    logic [ALU_SIZE-1:0]                 lane_en;
    logic [ALU_SIZE-1:0]                 lane_we;
    logic [ALU_SIZE-1:0][PREG_WIDTH-1:0] lane_rd;

    iq_dispatch i_dispatch (
        .clk           (clk),
        .rst_n         (rst_n),
        .disp_valid    (disp_valid),
        .disp_op       (disp_op),
        .disp_rs1      (disp_rs1),
        .disp_rs2      (disp_rs2),
        .disp_rd       (disp_rd),
        .disp_we       (disp_we),
        .wakeup_en     (wakeup_en),
        .wakeup_we     (wakeup_we),
        .wakeup_rd     (wakeup_rd),
        .entry_free    (entry_free),
        .disp_ready    (disp_ready),
        .alloc         (alloc),
        .alloc_op      (alloc_op),
        .alloc_rs1     (alloc_rs1),
        .alloc_rs2     (alloc_rs2),
        .alloc_rd      (alloc_rd),
        .alloc_we      (alloc_we),
        .alloc_rs1_rdy (alloc_rs1_rdy),
        .alloc_rs2_rdy (alloc_rs2_rdy)
    );

    // ----------------------------------------
    // Queue slots
    // ----------------------------------------

    for (genvar s = 0; s < IQ_DEPTH; s++) begin : g_entry
        assign entry_free[s] = (entry_state[s] == ENTRY_FREE);

        iq_entry i_entry (
            .clk           (clk),
            .rst_n         (rst_n),
            .alloc         (alloc[s]),
            .alloc_op      (alloc_op),
            .alloc_rs1     (alloc_rs1),
            .alloc_rs2     (alloc_rs2),
            .alloc_rd      (alloc_rd),
            .alloc_we      (alloc_we),
            .alloc_rs1_rdy (alloc_rs1_rdy),
            .alloc_rs2_rdy (alloc_rs2_rdy),
            .wakeup_en     (wakeup_en),
            .wakeup_we     (wakeup_we),
            .wakeup_rd     (wakeup_rd),
            .clear         (clear[s]),
            .state         (entry_state[s]),
            .op            (entry_op[s]),
            .rs1           (entry_rs1[s]),
            .rs2           (entry_rs2[s]),
            .rd            (entry_rd[s]),
            .we            (entry_we[s])
        );
    end

    issue_select i_select (
        .clk         (clk),
        .rst_n       (rst_n),
        .state       (entry_state),
        .op          (entry_op),
        .rs1         (entry_rs1),
        .rs2         (entry_rs2),
        .rd          (entry_rd),
        .we          (entry_we),
        .lane_ready  (lane_ready),
        .clear       (clear),
        .lane_en     (lane_en),
        .lane_we     (lane_we),
        .lane_rd     (lane_rd),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_rd    (issue_rd),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2)
    );

    wakeup_merge i_merge (
        .lane_en          (lane_en),
        .lane_we          (lane_we),
        .lane_rd          (lane_rd),
        .muldiv_wakeup_en (muldiv_wakeup_en),
        .muldiv_wakeup_we (muldiv_wakeup_we),
        .muldiv_wakeup_rd (muldiv_wakeup_rd),
        .load_wakeup_en   (load_wakeup_en),
        .load_wakeup_we   (load_wakeup_we),
        .load_wakeup_rd   (load_wakeup_rd),
        .lane_ready       (lane_ready),
        .wakeup_en        (wakeup_en),
        .wakeup_we        (wakeup_we),
        .wakeup_rd        (wakeup_rd)
    );

endmodule

`default_nettype wire

//--- source/wakeup_merge.sv
`default_nettype none

module wakeup_merge (
    input  logic [core_cfg_pkg::ALU_SIZE-1:0]                           lane_en,
    input  logic [core_cfg_pkg::ALU_SIZE-1:0]                           lane_we,
    input  logic [core_cfg_pkg::ALU_SIZE-1:0][core_cfg_pkg::PREG_WIDTH-1:0] lane_rd,
    input  logic                                                        muldiv_wakeup_en,
    input  logic                                                        muldiv_wakeup_we,
    input  logic [core_cfg_pkg::PREG_WIDTH-1:0]                         muldiv_wakeup_rd,
    input  logic [core_cfg_pkg::LOAD_PIPELINE-1:0]                      load_wakeup_en,
    input  logic [core_cfg_pkg::LOAD_PIPELINE-1:0]                      load_wakeup_we,
    input  logic [core_cfg_pkg::LOAD_PIPELINE-1:0][core_cfg_pkg::PREG_WIDTH-1:0] load_wakeup_rd,
    output logic [core_cfg_pkg::ALU_SIZE-1:0]                           lane_ready,
    output logic [core_cfg_pkg::WAKEUP_SIZE-1:0]                        wakeup_en,
    output logic [core_cfg_pkg::WAKEUP_SIZE-1:0]                        wakeup_we,
    output logic [core_cfg_pkg::WAKEUP_SIZE-1:0][core_cfg_pkg::PREG_WIDTH-1:0] wakeup_rd
);

    import core_cfg_pkg::*;

    // ----------------------------------------
    // ALU part of the bus
    // ----------------------------------------

    for (genvar i = 0; i < ALU_SIZE; i++) begin : g_lane
        if (i == MULDIV_LANE) begin : g_shared
            // Multiply/divide owns the slot and blocks the lane this cycle.
            assign lane_ready[i] = ~muldiv_wakeup_en;
            assign wakeup_en[i]  = lane_en[i] | muldiv_wakeup_en;
            assign wakeup_we[i]  = muldiv_wakeup_en ? muldiv_wakeup_we : lane_we[i];
            assign wakeup_rd[i]  = muldiv_wakeup_en ? muldiv_wakeup_rd : lane_rd[i];
        end else begin : g_alu
            assign lane_ready[i] = 1'b1;
            assign wakeup_en[i]  = lane_en[i];
            assign wakeup_we[i]  = lane_we[i];
            assign wakeup_rd[i]  = lane_rd[i];
        end
    end

    // Load ports sit above the ALU lanes.
    assign wakeup_en[WAKEUP_SIZE-1:ALU_SIZE] = load_wakeup_en;
    assign wakeup_we[WAKEUP_SIZE-1:ALU_SIZE] = load_wakeup_we;
    assign wakeup_rd[WAKEUP_SIZE-1:ALU_SIZE] = load_wakeup_rd;

endmodule

`default_nettype wire

//--- source/issue_select.sv
`default_nettype none

module issue_select (
    input  logic                                                        clk,
    input  logic                                                        rst_n,
    input  uop_pkg::entry_state_e [core_cfg_pkg::IQ_DEPTH-1:0]          state,
    input  uop_pkg::uop_op_e [core_cfg_pkg::IQ_DEPTH-1:0]               op,
    input  logic [core_cfg_pkg::IQ_DEPTH-1:0][core_cfg_pkg::PREG_WIDTH-1:0] rs1,
    input  logic [core_cfg_pkg::IQ_DEPTH-1:0][core_cfg_pkg::PREG_WIDTH-1:0] rs2,
    input  logic [core_cfg_pkg::IQ_DEPTH-1:0][core_cfg_pkg::PREG_WIDTH-1:0] rd,
    input  logic [core_cfg_pkg::IQ_DEPTH-1:0]                           we,
    input  logic [core_cfg_pkg::ALU_SIZE-1:0]                           lane_ready,
    output logic [core_cfg_pkg::IQ_DEPTH-1:0]                           clear,
    output logic [core_cfg_pkg::ALU_SIZE-1:0]                           lane_en,
    output logic [core_cfg_pkg::ALU_SIZE-1:0]                           lane_we,
    output logic [core_cfg_pkg::ALU_SIZE-1:0][core_cfg_pkg::PREG_WIDTH-1:0] lane_rd,
    output logic [core_cfg_pkg::ALU_SIZE-1:0]                           issue_valid,
    output uop_pkg::uop_op_e [core_cfg_pkg::ALU_SIZE-1:0]               issue_op,
    output logic [core_cfg_pkg::ALU_SIZE-1:0][core_cfg_pkg::PREG_WIDTH-1:0] issue_rd,
    output logic [core_cfg_pkg::ALU_SIZE-1:0][core_cfg_pkg::PREG_WIDTH-1:0] issue_rs1,
    output logic [core_cfg_pkg::ALU_SIZE-1:0][core_cfg_pkg::PREG_WIDTH-1:0] issue_rs2
);

    import core_cfg_pkg::*;
    import uop_pkg::*;

    logic [ALU_SIZE-1:0]                   pick_en;
    logic [ALU_SIZE-1:0][IQ_IDX_WIDTH-1:0] pick_idx;
    logic [IQ_DEPTH-1:0]                   taken;

    // ----------------------------------------
    // Pick
    // ----------------------------------------

    // Each available lane takes the lowest ready slot left by earlier lanes.
    always_comb begin
        pick_en  = '0;
        pick_idx = '0;
        taken    = '0;
        for (int l = 0; l < ALU_SIZE; l++) begin
            for (int s = 0; s < IQ_DEPTH; s++) begin
                if (lane_ready[l] && !pick_en[l] && !taken[s] && state[s] == ENTRY_READY) begin
                    pick_en[l]  = 1'b1;
                    pick_idx[l] = IQ_IDX_WIDTH'(s);
                    taken[s]    = 1'b1;
                end
            end
        end
    end

    assign clear   = taken;
    assign lane_en = pick_en;

    // Destination goes on the bus in the pick cycle.
    always_comb begin
        for (int l = 0; l < ALU_SIZE; l++) begin
            lane_we[l] = pick_en[l] & we[pick_idx[l]];
            lane_rd[l] = rd[pick_idx[l]];
        end
    end

    // ----------------------------------------
    // Issue registers
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_valid <= '0;
        end else begin
            issue_valid <= pick_en;
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < ALU_SIZE; l++) begin
            if (pick_en[l]) begin
                issue_op[l]  <= op[pick_idx[l]];
                issue_rd[l]  <= rd[pick_idx[l]];
                issue_rs1[l] <= rs1[pick_idx[l]];
                issue_rs2[l] <= rs2[pick_idx[l]];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/iq_entry.sv
`default_nettype none

module iq_entry (
    input  logic                                                        clk,
    input  logic                                                        rst_n,
    input  logic                                                        alloc,
    input  uop_pkg::uop_op_e                                            alloc_op,
    input  logic [core_cfg_pkg::PREG_WIDTH-1:0]                         alloc_rs1,
    input  logic [core_cfg_pkg::PREG_WIDTH-1:0]                         alloc_rs2,
    input  logic [core_cfg_pkg::PREG_WIDTH-1:0]                         alloc_rd,
    input  logic                                                        alloc_we,
    input  logic                                                        alloc_rs1_rdy,
    input  logic                                                        alloc_rs2_rdy,
    input  logic [core_cfg_pkg::WAKEUP_SIZE-1:0]                        wakeup_en,
    input  logic [core_cfg_pkg::WAKEUP_SIZE-1:0]                        wakeup_we,
    input  logic [core_cfg_pkg::WAKEUP_SIZE-1:0][core_cfg_pkg::PREG_WIDTH-1:0] wakeup_rd,
    input  logic                                                        clear,
    output uop_pkg::entry_state_e                                       state,
    output uop_pkg::uop_op_e                                            op,
    output logic [core_cfg_pkg::PREG_WIDTH-1:0]                         rs1,
    output logic [core_cfg_pkg::PREG_WIDTH-1:0]                         rs2,
    output logic [core_cfg_pkg::PREG_WIDTH-1:0]                         rd,
    output logic                                                        we
);

    import core_cfg_pkg::*;
    import uop_pkg::*;

    logic rs1_rdy;
    logic rs2_rdy;
    logic rs1_hit;
    logic rs2_hit;
    logic rs1_nxt;
    logic rs2_nxt;

    // Match both sources against every wakeup port.
    always_comb begin
        rs1_hit = 1'b0;
        rs2_hit = 1'b0;
        for (int i = 0; i < WAKEUP_SIZE; i++) begin
            if (wakeup_en[i] && wakeup_we[i]) begin
                if (wakeup_rd[i] == rs1) begin
                    rs1_hit = 1'b1;
                end
                if (wakeup_rd[i] == rs2) begin
                    rs2_hit = 1'b1;
                end
            end
        end
    end

    assign rs1_nxt = rs1_rdy | rs1_hit;
    assign rs2_nxt = rs2_rdy | rs2_hit;

    // ----------------------------------------
    // Slot state
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ENTRY_FREE;
            rs1_rdy <= 1'b0;
            rs2_rdy <= 1'b0;
        end else begin
            case (state)
                ENTRY_FREE: begin
                    if (alloc) begin
                        rs1_rdy <= alloc_rs1_rdy;
                        rs2_rdy <= alloc_rs2_rdy;
                        state   <= (alloc_rs1_rdy && alloc_rs2_rdy) ? ENTRY_READY : ENTRY_WAIT;
                    end
                end
                ENTRY_WAIT: begin
                    rs1_rdy <= rs1_nxt;
                    rs2_rdy <= rs2_nxt;
                    if (rs1_nxt && rs2_nxt) begin
                        state <= ENTRY_READY;
                    end
                end
                ENTRY_READY: begin
                    if (clear) begin
                        state <= ENTRY_FREE;
                    end
                end
                default: state <= ENTRY_FREE;
            endcase
        end
    end

    // Payload is only written on allocation.
    always_ff @(posedge clk) begin
        if (alloc) begin
            op  <= alloc_op;
            rs1 <= alloc_rs1;
            rs2 <= alloc_rs2;
            rd  <= alloc_rd;
            we  <= alloc_we;
        end
    end

endmodule

`default_nettype wire

//--- source/iq_dispatch.sv
`default_nettype none

module iq_dispatch (
    input  logic                                                        clk,
    input  logic                                                        rst_n,
    input  logic                                                        disp_valid,
    input  uop_pkg::uop_op_e                                            disp_op,
    input  logic [core_cfg_pkg::PREG_WIDTH-1:0]                         disp_rs1,
    input  logic [core_cfg_pkg::PREG_WIDTH-1:0]                         disp_rs2,
    input  logic [core_cfg_pkg::PREG_WIDTH-1:0]                         disp_rd,
    input  logic                                                        disp_we,
    input  logic [core_cfg_pkg::WAKEUP_SIZE-1:0]                        wakeup_en,
    input  logic [core_cfg_pkg::WAKEUP_SIZE-1:0]                        wakeup_we,
    input  logic [core_cfg_pkg::WAKEUP_SIZE-1:0][core_cfg_pkg::PREG_WIDTH-1:0] wakeup_rd,
    input  logic [core_cfg_pkg::IQ_DEPTH-1:0]                           entry_free,
    output logic                                                        disp_ready,
    output logic [core_cfg_pkg::IQ_DEPTH-1:0]                           alloc,
    output uop_pkg::uop_op_e                                            alloc_op,
    output logic [core_cfg_pkg::PREG_WIDTH-1:0]                         alloc_rs1,
    output logic [core_cfg_pkg::PREG_WIDTH-1:0]                         alloc_rs2,
    output logic [core_cfg_pkg::PREG_WIDTH-1:0]                         alloc_rd,
    output logic                                                        alloc_we,
    output logic                                                        alloc_rs1_rdy,
    output logic                                                        alloc_rs2_rdy
);

    import core_cfg_pkg::*;

    logic [PREG_NUM-1:0] busy;
    logic [IQ_DEPTH-1:0] free_low;

    // A source is ready if it is p0, not busy, or woken this cycle.
    function automatic logic src_ready(input logic [PREG_WIDTH-1:0] src);
        logic rdy;
        rdy = (src == '0) || !busy[src];
        for (int i = 0; i < WAKEUP_SIZE; i++) begin
            if (wakeup_en[i] && wakeup_we[i] && wakeup_rd[i] == src) begin
                rdy = 1'b1;
            end
        end
        return rdy;
    endfunction

    // ----------------------------------------
    // Slot allocation
    // ----------------------------------------

    // Isolate the lowest free slot.
    assign free_low   = entry_free & (~entry_free + 1'b1);
    assign disp_ready = |entry_free;
    assign alloc      = disp_valid ? free_low : '0;

    assign alloc_op  = disp_op;
    assign alloc_rs1 = disp_rs1;
    assign alloc_rs2 = disp_rs2;
    assign alloc_rd  = disp_rd;
    assign alloc_we  = disp_we;

    always_comb begin
        alloc_rs1_rdy = src_ready(disp_rs1);
        alloc_rs2_rdy = src_ready(disp_rs2);
    end

    // ----------------------------------------
    // Busy table
    // ----------------------------------------

    // A new producer wins over a wakeup of the same register.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            for (int i = 0; i < WAKEUP_SIZE; i++) begin
                if (wakeup_en[i] && wakeup_we[i]) begin
                    busy[wakeup_rd[i]] <= 1'b0;
                end
            end
            if (|alloc && disp_we && disp_rd != '0) begin
                busy[disp_rd] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/uop_pkg.sv
`default_nettype none

package uop_pkg;

    // ALU operation carried through the queue.
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLT = 3'd5
    } uop_op_e;

    // Slot life cycle.
    // WAIT holds until both sources have seen a wakeup.
    typedef enum logic [1:0] {
        ENTRY_FREE  = 2'd0,
        ENTRY_WAIT  = 2'd1,
        ENTRY_READY = 2'd2
    } entry_state_e;

endpackage

`default_nettype wire

//--- source/core_cfg_pkg.sv
`default_nettype none

package core_cfg_pkg;

    // ----------------------------------------
    // Issue lanes and wakeup ports
    // ----------------------------------------

    // Single-cycle ALU lanes.
    localparam int ALU_SIZE = 2;

    // Load pipelines that broadcast early wakeups.
    localparam int LOAD_PIPELINE = 1;

    // ALU lanes first, then the load ports.
    localparam int WAKEUP_SIZE = ALU_SIZE + LOAD_PIPELINE;

    // Lane whose wakeup slot multiply/divide takes over.
    localparam int MULDIV_LANE = 0;

    // ----------------------------------------
    // Register file and queue
    // ----------------------------------------

    localparam int PREG_WIDTH = 6;
    localparam int PREG_NUM   = 64;

    localparam int IQ_DEPTH     = 8;
    localparam int IQ_IDX_WIDTH = 3;

endpackage

`default_nettype wire
